/* source/fabric_cfg.svh */
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// ***************************************************************************
// address map.
// ***************************************************************************

`define ITIM_BASE 32'h0000_0000
`define ITIM_SIZE 32'h0000_0400

`define DTIM_BASE 32'h0001_0000
`define DTIM_SIZE 32'h0000_0400

`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

`define RAM_BASE 32'h8000_0000
`define RAM_SIZE 32'h0000_0400

// words per memory.
`define TIM_WORDS 256

// clocks per mtime increment.
`define CLINT_TICK 4

`endif

/* source/fabric_pkg.sv */
package fabric_pkg;

  // data and address word.
  typedef logic [31:0] word_t;

  // byte enables, all zero is a read.
  typedef logic [3:0] strb_t;

  // peripheral arbiter states.
  typedef enum logic [1:0] {
    arb_idle,
    arb_instr,
    arb_data
  } arb_state_t;

  // owner of a pending tim response.
  typedef enum logic {
    route_instr,
    route_data
  } route_t;

endpackage

/* source/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;

  logic valid;
  fabric_pkg::word_t addr;
  fabric_pkg::word_t wdata;
  fabric_pkg::strb_t strb;
  logic ready;
  fabric_pkg::word_t rdata;

  modport requester (
    output valid,
    output addr,
    output wdata,
    output strb,
    input  ready,
    input  rdata
  );

  modport responder (
    input  valid,
    input  addr,
    input  wdata,
    input  strb,
    output ready,
    output rdata
  );

endinterface

/* source/tim.sv */
`timescale 1ns/1ps

`include "fabric_cfg.svh"

module tim #(
  parameter int depth = `TIM_WORDS
) (
  input logic clock,
  input logic reset,
  mem_bus_if.responder bus
);

  localparam int aw = $clog2(depth);

  fabric_pkg::word_t mem [depth];
  fabric_pkg::word_t rdata_q;
  logic ready_q;
  logic [aw-1:0] index;

  // word index without the byte offset bits.
  assign index = bus.addr[aw+1:2];

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.strb[b]) begin
          mem[index][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  // an offset past the array would alias onto a lower word.
  a_in_range: assert property (
    @(posedge clock) disable iff (!reset)
    bus.valid |-> bus.addr < fabric_pkg::word_t'(depth * 4)
  );

endmodule

/* source/arbiter.sv */
`timescale 1ns/1ps

module arbiter (
  input logic clock,
  input logic reset,
  mem_bus_if.responder instr_bus,
  mem_bus_if.responder data_bus,
  mem_bus_if.requester per_bus
);

  fabric_pkg::arb_state_t state;
  fabric_pkg::arb_state_t state_next;

  logic instr_pend;
  fabric_pkg::word_t instr_addr_q;
  fabric_pkg::word_t instr_wdata_q;
  fabric_pkg::strb_t instr_strb_q;

  logic data_pend;
  fabric_pkg::word_t data_addr_q;
  fabric_pkg::word_t data_wdata_q;
  fabric_pkg::strb_t data_strb_q;

  // ***************************************************************************
  // one pending latch per side.
  // ***************************************************************************

  always_ff @(posedge clock) begin
    if (instr_bus.valid) begin
      instr_addr_q  <= instr_bus.addr;
      instr_wdata_q <= instr_bus.wdata;
      instr_strb_q  <= instr_bus.strb;
    end
    if (data_bus.valid) begin
      data_addr_q  <= data_bus.addr;
      data_wdata_q <= data_bus.wdata;
      data_strb_q  <= data_bus.strb;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      instr_pend <= 1'b0;
      data_pend  <= 1'b0;
      state      <= fabric_pkg::arb_idle;
    end else begin
      if (instr_bus.valid) begin
        instr_pend <= 1'b1;
      end else if (instr_bus.ready) begin
        instr_pend <= 1'b0;
      end
      if (data_bus.valid) begin
        data_pend <= 1'b1;
      end else if (data_bus.ready) begin
        data_pend <= 1'b0;
      end
      state <= state_next;
    end
  end

  // ***************************************************************************
  // grant and issue.
  // ***************************************************************************

  always_comb begin
    state_next = state;
    case (state)
      fabric_pkg::arb_idle: begin
        if (instr_pend) begin
          state_next = fabric_pkg::arb_instr;
        end else if (data_pend) begin
          state_next = fabric_pkg::arb_data;
        end
      end
      fabric_pkg::arb_instr, fabric_pkg::arb_data: begin
        // the other side, if pending, is issued from idle next cycle.
        if (per_bus.ready) begin
          state_next = fabric_pkg::arb_idle;
        end
      end
      default: state_next = fabric_pkg::arb_idle;
    endcase
  end

  // instr wins when both are pending.
  assign per_bus.valid = (state == fabric_pkg::arb_idle) && (instr_pend || data_pend);
  assign per_bus.addr  = instr_pend ? instr_addr_q : data_addr_q;
  assign per_bus.wdata = instr_pend ? instr_wdata_q : data_wdata_q;
  assign per_bus.strb  = instr_pend ? instr_strb_q : data_strb_q;

  assign instr_bus.ready = (state == fabric_pkg::arb_instr) && per_bus.ready;
  assign instr_bus.rdata = per_bus.rdata;
  assign data_bus.ready  = (state == fabric_pkg::arb_data) && per_bus.ready;
  assign data_bus.rdata  = per_bus.rdata;

  // a peripheral answers only a request that was issued.
  a_answer: assert property (
    @(posedge clock) disable iff (!reset)
    per_bus.ready |-> (state != fabric_pkg::arb_idle)
  );

  a_instr_free: assert property (
    @(posedge clock) disable iff (!reset)
    instr_bus.valid |-> !instr_pend
  );

  a_data_free: assert property (
    @(posedge clock) disable iff (!reset)
    data_bus.valid |-> !data_pend
  );

endmodule

/* source/clint.sv */
`timescale 1ns/1ps

`include "fabric_cfg.svh"

module clint #(
  parameter int tick = `CLINT_TICK
) (
  input logic clock,
  input logic reset,
  mem_bus_if.responder bus,
  output logic msip,
  output logic mtip
);

  localparam int cw = (tick > 1) ? $clog2(tick) : 1;

  localparam logic [15:0] off_msip       = 16'h0000;
  localparam logic [15:0] off_mtimecmp_l = 16'h4000;
  localparam logic [15:0] off_mtimecmp_h = 16'h4004;
  localparam logic [15:0] off_mtime_l    = 16'hbff8;
  localparam logic [15:0] off_mtime_h    = 16'hbffc;

  logic [cw-1:0] div_q;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic msip_q;
  logic ready_q;
  fabric_pkg::word_t rdata_q;
  logic wr;

  function automatic fabric_pkg::word_t merge(fabric_pkg::word_t old_word,
                                              fabric_pkg::word_t new_word,
                                              fabric_pkg::strb_t strb);
    fabric_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  assign wr = bus.valid && (bus.strb != '0);

  always_ff @(posedge clock) begin
    if (!reset) begin
      div_q    <= '0;
      mtime    <= '0;
      mtimecmp <= '1;
      msip_q   <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= bus.valid;
      if (div_q == cw'(tick - 1)) begin
        div_q <= '0;
        mtime <= mtime + 64'd1;
      end else begin
        div_q <= div_q + 1'b1;
      end
      if (wr) begin
        case (bus.addr[15:0])
          off_msip:       if (bus.strb[0]) msip_q <= bus.wdata[0];
          off_mtimecmp_l: mtimecmp[31:0]  <= merge(mtimecmp[31:0], bus.wdata, bus.strb);
          off_mtimecmp_h: mtimecmp[63:32] <= merge(mtimecmp[63:32], bus.wdata, bus.strb);
          default: ;
        endcase
      end
    end
  end

  // unknown offsets read as zero.
  always_ff @(posedge clock) begin
    if (bus.valid) begin
      case (bus.addr[15:0])
        off_msip:       rdata_q <= {31'b0, msip_q};
        off_mtimecmp_l: rdata_q <= mtimecmp[31:0];
        off_mtimecmp_h: rdata_q <= mtimecmp[63:32];
        off_mtime_l:    rdata_q <= mtime[31:0];
        off_mtime_h:    rdata_q <= mtime[63:32];
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign msip = msip_q;
  assign mtip = (mtime >= mtimecmp);

  // registers are whole words.
  a_aligned: assert property (
    @(posedge clock) disable iff (!reset)
    bus.valid |-> bus.addr[1:0] == 2'b00
  );

endmodule

/* source/soc_fabric.sv */
`timescale 1ns/1ps

`include "fabric_cfg.svh"

module soc_fabric (
  input  logic clock,
  input  logic reset,
  input  logic instr_valid,
  input  fabric_pkg::word_t instr_addr,
  input  fabric_pkg::word_t instr_wdata,
  input  fabric_pkg::strb_t instr_strb,
  output logic instr_ready,
  output fabric_pkg::word_t instr_rdata,
  input  logic data_valid,
  input  fabric_pkg::word_t data_addr,
  input  fabric_pkg::word_t data_wdata,
  input  fabric_pkg::strb_t data_strb,
  output logic data_ready,
  output fabric_pkg::word_t data_rdata,
  output logic msip,
  output logic mtip
);

  mem_bus_if itim_bus ();
  mem_bus_if dtim_bus ();
  mem_bus_if iper_bus ();
  mem_bus_if dper_bus ();
  mem_bus_if per_bus ();
  mem_bus_if ram_bus ();
  mem_bus_if clint_bus ();

  logic hit_itim_i, hit_itim_d, hit_dtim_i, hit_dtim_d;
  logic itim_take_i, itim_take_d, dtim_take_i, dtim_take_d;
  fabric_pkg::route_t itim_route_q;
  fabric_pkg::route_t dtim_route_q;
  logic hit_ram, hit_clint;
  logic unmapped_q;

  // wraps below base, so one unsigned compare covers both bounds.
  function automatic logic in_range(fabric_pkg::word_t addr, fabric_pkg::word_t base,
                                    fabric_pkg::word_t size);
    return (addr - base) < size;
  endfunction

  // ***************************************************************************
  // tim routing, instr port first.
  // ***************************************************************************

  assign hit_itim_i = in_range(instr_addr, `ITIM_BASE, `ITIM_SIZE);
  assign hit_itim_d = in_range(data_addr, `ITIM_BASE, `ITIM_SIZE);
  assign hit_dtim_i = in_range(instr_addr, `DTIM_BASE, `DTIM_SIZE);
  assign hit_dtim_d = in_range(data_addr, `DTIM_BASE, `DTIM_SIZE);

  assign itim_take_i = instr_valid && hit_itim_i;
  assign itim_take_d = !itim_take_i && data_valid && hit_itim_d;
  assign dtim_take_i = instr_valid && hit_dtim_i;
  assign dtim_take_d = !dtim_take_i && data_valid && hit_dtim_d;

  assign itim_bus.valid = itim_take_i || itim_take_d;
  assign itim_bus.addr  = (itim_take_d ? data_addr : instr_addr) - `ITIM_BASE;
  assign itim_bus.wdata = itim_take_d ? data_wdata : instr_wdata;
  assign itim_bus.strb  = itim_take_d ? data_strb : instr_strb;

  assign dtim_bus.valid = dtim_take_i || dtim_take_d;
  assign dtim_bus.addr  = (dtim_take_d ? data_addr : instr_addr) - `DTIM_BASE;
  assign dtim_bus.wdata = dtim_take_d ? data_wdata : instr_wdata;
  assign dtim_bus.strb  = dtim_take_d ? data_strb : instr_strb;

  // remembers who asked, for the response in the next cycle.
  always_ff @(posedge clock) begin
    if (!reset) begin
      itim_route_q <= fabric_pkg::route_instr;
      dtim_route_q <= fabric_pkg::route_instr;
    end else begin
      if (itim_bus.valid) begin
        itim_route_q <= itim_take_d ? fabric_pkg::route_data : fabric_pkg::route_instr;
      end
      if (dtim_bus.valid) begin
        dtim_route_q <= dtim_take_d ? fabric_pkg::route_data : fabric_pkg::route_instr;
      end
    end
  end

  // everything outside both tims goes to the arbiter with its full address.
  assign iper_bus.valid = instr_valid && !hit_itim_i && !hit_dtim_i;
  assign iper_bus.addr  = instr_addr;
  assign iper_bus.wdata = instr_wdata;
  assign iper_bus.strb  = instr_strb;

  assign dper_bus.valid = data_valid && !hit_itim_d && !hit_dtim_d;
  assign dper_bus.addr  = data_addr;
  assign dper_bus.wdata = data_wdata;
  assign dper_bus.strb  = data_strb;

  // ***************************************************************************
  // response return.
  // ***************************************************************************

  always_comb begin
    instr_ready = 1'b0;
    instr_rdata = '0;
    data_ready  = 1'b0;
    data_rdata  = '0;
    if (itim_bus.ready && itim_route_q == fabric_pkg::route_instr) begin
      instr_ready = 1'b1;
      instr_rdata = itim_bus.rdata;
    end
    if (itim_bus.ready && itim_route_q == fabric_pkg::route_data) begin
      data_ready = 1'b1;
      data_rdata = itim_bus.rdata;
    end
    if (dtim_bus.ready && dtim_route_q == fabric_pkg::route_instr) begin
      instr_ready = 1'b1;
      instr_rdata = dtim_bus.rdata;
    end
    if (dtim_bus.ready && dtim_route_q == fabric_pkg::route_data) begin
      data_ready = 1'b1;
      data_rdata = dtim_bus.rdata;
    end
    if (iper_bus.ready) begin
      instr_ready = 1'b1;
      instr_rdata = iper_bus.rdata;
    end
    if (dper_bus.ready) begin
      data_ready = 1'b1;
      data_rdata = dper_bus.rdata;
    end
  end

  // ***************************************************************************
  // peripheral decode.
  // ***************************************************************************

  assign hit_ram   = in_range(per_bus.addr, `RAM_BASE, `RAM_SIZE);
  assign hit_clint = in_range(per_bus.addr, `CLINT_BASE, `CLINT_SIZE);

  assign ram_bus.valid = per_bus.valid && hit_ram;
  assign ram_bus.addr  = per_bus.addr - `RAM_BASE;
  assign ram_bus.wdata = per_bus.wdata;
  assign ram_bus.strb  = per_bus.strb;

  assign clint_bus.valid = per_bus.valid && hit_clint;
  assign clint_bus.addr  = per_bus.addr - `CLINT_BASE;
  assign clint_bus.wdata = per_bus.wdata;
  assign clint_bus.strb  = per_bus.strb;

  // unmapped accesses answer zero so the requester does not hang.
  always_ff @(posedge clock) begin
    if (!reset) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= per_bus.valid && !hit_ram && !hit_clint;
    end
  end

  assign per_bus.ready = ram_bus.ready || clint_bus.ready || unmapped_q;
  assign per_bus.rdata = ram_bus.ready   ? ram_bus.rdata :
                         clint_bus.ready ? clint_bus.rdata : '0;

  tim #(.depth(`ITIM_SIZE / 4)) itim_comp (
    .clock(clock),
    .reset(reset),
    .bus  (itim_bus)
  );

  tim #(.depth(`DTIM_SIZE / 4)) dtim_comp (
    .clock(clock),
    .reset(reset),
    .bus  (dtim_bus)
  );

  tim #(.depth(`RAM_SIZE / 4)) ram_comp (
    .clock(clock),
    .reset(reset),
    .bus  (ram_bus)
  );

  arbiter arbiter_comp (
    .clock    (clock),
    .reset    (reset),
    .instr_bus(iper_bus),
    .data_bus (dper_bus),
    .per_bus  (per_bus)
  );

  clint #(.tick(`CLINT_TICK)) clint_comp (
    .clock(clock),
    .reset(reset),
    .bus  (clint_bus),
    .msip (msip),
    .mtip (mtip)
  );

  // a tim serves one port per cycle.
  a_itim_conflict: assert property (
    @(posedge clock) disable iff (!reset)
    !(instr_valid && hit_itim_i && data_valid && hit_itim_d)
  );

  a_dtim_conflict: assert property (
    @(posedge clock) disable iff (!reset)
    !(instr_valid && hit_dtim_i && data_valid && hit_dtim_d)
  );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period = 10,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // reset releases just after a rising edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

/* test/soc_fabric_tb.sv */
`timescale 1ns/1ps

`include "fabric_cfg.svh"

module soc_fabric_tb;

  localparam int words = `TIM_WORDS;
  localparam int n_tim = 400;
  localparam int n_ram = 120;
  localparam int n_pairs = 40;
  localparam int n_clint = 24;
  localparam int n_accesses = 3 * words + 2 * n_tim + n_ram + 2 * n_pairs + n_clint;
  localparam int timeout_cycles = n_accesses * 20 + 2000;

  logic clock;
  logic reset;

  // index 0 is the instr port, index 1 the data port.
  logic [1:0] req_valid;
  fabric_pkg::word_t req_addr [2];
  fabric_pkg::word_t req_wdata [2];
  fabric_pkg::strb_t req_strb [2];
  logic [1:0] resp_ready;
  fabric_pkg::word_t resp_rdata [2];
  logic msip;
  logic mtip;

  logic [1:0] chk;
  logic [1:0] outst;
  fabric_pkg::word_t exp_rdata [2];
  fabric_pkg::word_t last_rdata [2];
  int lat [2];

  logic started;
  logic contend;
  logic level_chk;
  logic msip_exp;
  logic mtip_exp;
  logic mtime_chk;
  fabric_pkg::word_t mtime_prev;
  fabric_pkg::word_t shadow [3][words];
  integer seed;

  tb_clock clock_gen (
    .clock(clock),
    .reset(reset)
  );

  soc_fabric uut (
    .clock      (clock),
    .reset      (reset),
    .instr_valid(req_valid[0]),
    .instr_addr (req_addr[0]),
    .instr_wdata(req_wdata[0]),
    .instr_strb (req_strb[0]),
    .instr_ready(resp_ready[0]),
    .instr_rdata(resp_rdata[0]),
    .data_valid (req_valid[1]),
    .data_addr  (req_addr[1]),
    .data_wdata (req_wdata[1]),
    .data_strb  (req_strb[1]),
    .data_ready (resp_ready[1]),
    .data_rdata (resp_rdata[1]),
    .msip       (msip),
    .mtip       (mtip)
  );

  function automatic string port_label(input int p);
    return (p == 0) ? "instr" : "data";
  endfunction

  function automatic fabric_pkg::word_t region_base(input int r);
    case (r)
      0: return `ITIM_BASE;
      1: return `DTIM_BASE;
      default: return `RAM_BASE;
    endcase
  endfunction

  function automatic fabric_pkg::word_t with_bytes(input fabric_pkg::word_t old_word,
                                                   input fabric_pkg::word_t wdata,
                                                   input fabric_pkg::strb_t strb);
    fabric_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (wdata & mask);
  endfunction

  // every address bit shows up in the word.
  function automatic fabric_pkg::word_t fill_pattern(input fabric_pkg::word_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic void value_mismatch(input string name, input fabric_pkg::word_t want,
                                         input fabric_pkg::word_t got);
    $display("FAIL %s expected 0x%08h got 0x%08h", name, want, got);
    $display("TB FAILED");
    $fatal(1);
  endfunction

  function automatic void run_failure(input string what);
    $display("ERROR %s", what);
    $display("TB FAILED");
    $fatal(1);
  endfunction

  // ***************************************************************************
  // request driving.
  // ***************************************************************************

  task automatic start_req(input int p, input fabric_pkg::word_t addr,
                           input fabric_pkg::word_t wdata, input fabric_pkg::strb_t strb,
                           input fabric_pkg::word_t want, input logic check,
                           input int latency);
    started = 1'b1;
    req_valid[p] = 1'b1;
    req_addr[p] = addr;
    req_wdata[p] = wdata;
    req_strb[p] = strb;
    exp_rdata[p] = want;
    chk[p] = check;
    lat[p] = latency;
    outst[p] = 1'b1;
  endtask

  task automatic await_ready(input int p);
    @(posedge clock);
    #1;
    req_valid[p] = 1'b0;
    @(negedge clock);
    while (!resp_ready[p]) begin
      @(negedge clock);
    end
    last_rdata[p] = resp_rdata[p];
    @(posedge clock);
    #1;
    outst[p] = 1'b0;
    chk[p] = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // region 0 is the itim, 1 the dtim, 2 the RAM.
  task automatic mem_start(input int p, input int r, input int idx, input logic write,
                           input int latency);
    fabric_pkg::word_t wdata;
    fabric_pkg::word_t rnd;
    fabric_pkg::strb_t strb;
    fabric_pkg::word_t old_word;
    wdata = $random(seed);
    rnd = $random(seed);
    strb = (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0];
    old_word = shadow[r][idx];
    if (write) begin
      shadow[r][idx] = with_bytes(old_word, wdata, strb);
    end
    start_req(p, region_base(r) + 32'(idx * 4), wdata, write ? strb : 4'h0, old_word,
              !write, latency);
  endtask

  // msip and mtip move while the write is in flight.
  task automatic clint_write(input fabric_pkg::word_t offset, input fabric_pkg::word_t wdata,
                             input logic new_msip, input logic new_mtip);
    level_chk = 1'b0;
    start_req(1, `CLINT_BASE + offset, wdata, 4'hf, '0, 1'b0, 2);
    await_ready(1);
    msip_exp = new_msip;
    mtip_exp = new_mtip;
    level_chk = 1'b1;
  endtask

  task automatic clint_read(input fabric_pkg::word_t offset, input fabric_pkg::word_t want,
                            input logic check);
    start_req(1, `CLINT_BASE + offset, '0, 4'h0, want, check, 2);
    await_ready(1);
  endtask

  // ***************************************************************************
  // checks.
  // ***************************************************************************

  for (genvar p = 0; p < 2; p++) begin : g_port
    a_rdata: assert property (
      @(posedge clock) disable iff (!reset)
      resp_ready[p] && chk[p] |-> resp_rdata[p] == exp_rdata[p]
    ) else value_mismatch($sformatf("%s_rdata", port_label(p)), exp_rdata[p],
                          $sampled(resp_rdata[p]));

    a_lat1: assert property (
      @(posedge clock) disable iff (!reset)
      req_valid[p] && lat[p] == 1 |=> resp_ready[p]
    ) else run_failure($sformatf("%s_ready did not come 1 cycle after valid", port_label(p)));

    a_lat2_early: assert property (
      @(posedge clock) disable iff (!reset)
      req_valid[p] && lat[p] == 2 |=> !resp_ready[p]
    ) else run_failure($sformatf("%s_ready came before 2 cycles", port_label(p)));

    a_lat2: assert property (
      @(posedge clock) disable iff (!reset)
      $past(req_valid[p] && lat[p] == 2, 2) |-> resp_ready[p]
    ) else run_failure($sformatf("%s_ready did not come 2 cycles after valid", port_label(p)));

    a_single: assert property (
      @(posedge clock) disable iff (!reset)
      resp_ready[p] |-> outst[p]
    ) else run_failure($sformatf("%s_ready pulsed with no request open", port_label(p)));
  end

  a_quiet: assert property (
    @(posedge clock) disable iff (!reset)
    !started |-> resp_ready == 2'b00 && !msip && !mtip
  ) else run_failure("ready or an interrupt rose before the first request");

  a_msip: assert property (
    @(posedge clock) disable iff (!reset)
    level_chk |-> msip == msip_exp
  ) else value_mismatch("msip", {31'b0, msip_exp}, {31'b0, $sampled(msip)});

  a_mtip: assert property (
    @(posedge clock) disable iff (!reset)
    level_chk |-> mtip == mtip_exp
  ) else value_mismatch("mtip", {31'b0, mtip_exp}, {31'b0, $sampled(mtip)});

  a_order: assert property (
    @(posedge clock) disable iff (!reset)
    contend && resp_ready[1] |-> !outst[0]
  ) else run_failure("data response arrived before the instr response");

  a_mtime: assert property (
    @(posedge clock) disable iff (!reset)
    mtime_chk && resp_ready[1] |-> resp_rdata[1] >= mtime_prev
  ) else value_mismatch("data_rdata (mtime minimum)", mtime_prev, $sampled(resp_rdata[1]));

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    run_failure($sformatf("timeout, run not finished after %0d cycles", timeout_cycles));
  end

  initial begin
    fabric_pkg::word_t rnd;
    fabric_pkg::word_t addr;
    int p;
    int r;
    seed = 32'hc662_8531;
    req_valid = 2'b00;
    chk = 2'b00;
    outst = 2'b00;
    for (int i = 0; i < 2; i++) begin
      req_addr[i] = '0;
      req_wdata[i] = '0;
      req_strb[i] = 4'h0;
      exp_rdata[i] = '0;
      last_rdata[i] = '0;
      lat[i] = 0;
    end
    started = 1'b0;
    contend = 1'b0;
    level_chk = 1'b1;
    msip_exp = 1'b0;
    mtip_exp = 1'b0;
    mtime_chk = 1'b0;
    mtime_prev = '0;
    @(posedge reset);
    idle_cycles(6);

    // fill all three memories.
    for (r = 0; r < 3; r++) begin
      for (int i = 0; i < words; i++) begin
        addr = region_base(r) + 32'(i * 4);
        shadow[r][i] = fill_pattern(addr);
        p = (r == 0) ? 0 : 1;
        start_req(p, addr, shadow[r][i], 4'hf, '0, 1'b0, (r == 2) ? 2 : 1);
        await_ready(p);
      end
    end

    for (int i = 0; i < n_tim; i++) begin
      rnd = $random(seed);
      p = int'(rnd[0]);
      r = int'(rnd[1]);
      if (rnd[4:3] == 2'b00) begin
        // each port on its own tim in the same cycle.
        mem_start(0, r, int'(rnd[15:8]), rnd[2], 1);
        mem_start(1, 1 - r, int'(rnd[23:16]), rnd[5], 1);
        fork
          await_ready(0);
          await_ready(1);
        join
      end else begin
        mem_start(p, r, int'(rnd[15:8]), rnd[2], 1);
        await_ready(p);
      end
    end

    for (int i = 0; i < n_ram; i++) begin
      rnd = $random(seed);
      p = int'(rnd[0]);
      mem_start(p, 2, int'(rnd[15:8]), rnd[2], 2);
      await_ready(p);
    end

    contend = 1'b1;
    for (int i = 0; i < n_pairs; i++) begin
      rnd = $random(seed);
      mem_start(0, 2, int'(rnd[15:8]), rnd[0], 2);
      mem_start(1, 2, int'(rnd[23:16]), rnd[1], 0);
      fork
        await_ready(0);
        await_ready(1);
      join
    end
    contend = 1'b0;

    clint_write(32'h0, 32'h1, 1'b1, 1'b0);
    clint_read(32'h0, 32'h1, 1'b1);
    clint_write(32'h0, 32'h0, 1'b0, 1'b0);
    clint_read(32'h0, 32'h0, 1'b1);
    clint_read(32'h4000, 32'hffff_ffff, 1'b1);
    clint_write(32'h4004, 32'h0, 1'b0, 1'b0);
    clint_write(32'h4000, 32'h8, 1'b0, 1'b1);
    clint_read(32'h4000, 32'h8, 1'b1);
    clint_write(32'h4004, 32'hffff_ffff, 1'b0, 1'b0);
    clint_read(32'h4004, 32'hffff_ffff, 1'b1);
    for (int i = 0; i < 6; i++) begin
      clint_read(32'hbff8, '0, 1'b0);
      mtime_prev = last_rdata[1];
      mtime_chk = 1'b1;
      idle_cycles(i);
    end
    mtime_chk = 1'b0;

    // unmapped space reads as zero.
    start_req(0, 32'h4000_0000, '0, 4'h0, '0, 1'b1, 2);
    await_ready(0);
    start_req(1, 32'h4000_0104, 32'h1234_5678, 4'hf, '0, 1'b1, 2);
    await_ready(1);
    start_req(1, 32'h0300_0000, '0, 4'h0, '0, 1'b1, 2);
    await_ready(1);

    idle_cycles(8);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/fabric_pkg.sv
source/mem_bus_if.sv
source/tim.sv
source/arbiter.sv
source/clint.sv
source/soc_fabric.sv
test/tb_clock.sv
test/soc_fabric_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_fabric_tb
FILELIST  ?= files.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
